// ==== ifu_sys.f ====
rtl/ifu_pkg.sv
rtl/ifu_icache.sv
rtl/ifu_fetch_ctrl.sv
rtl/ifu_top.sv
test/tb_clkgen.sv
test/ifu_assertions.sv
test/ifu_tb.sv

// ==== test/ifu_tb.sv ====
`timescale 1ns/10ps

module ifu_tb;
  import ifu_pkg::*;

  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 2000;
  localparam int CLK_PERIOD_NS   = 8;
  localparam int MEM_WORDS       = 256;

  logic            clk;
  logic            rst;
  logic [XLEN-1:0] mem_araddr;
  logic            mem_arvalid;
  logic [XLEN-1:0] mem_rdata;
  logic            mem_rvalid;
  logic [XLEN-1:0] inst;
  logic [XLEN-1:0] pc;
  logic            valid;
  logic            ready;
  logic            resolve_valid;
  logic [XLEN-1:0] resolve_pc;
  logic            spec;
  logic            good_spec;
  logic            bad_spec;

  logic [XLEN-1:0] mem [MEM_WORDS];
  integer          seed;
  string           test_name;
  logic            bp_en;
  int              mem_reqs;
  int              good_cnt;
  int              bad_cnt;
  logic            held;
  logic [XLEN-1:0] held_pc;
  logic [XLEN-1:0] held_inst;
  logic [XLEN-1:0] got_pc [$];
  logic [XLEN-1:0] got_inst [$];
  logic            got_spec [$];
  logic [XLEN-1:0] exp_pc [$];
  logic [XLEN-1:0] exp_inst [$];
  logic            exp_spec [$];

  tb_clkgen tb_clkgen_inst (.clk_o(clk));

  ifu_top ifu_top_inst (
    .clk             (clk),
    .rst             (rst),
    .mem_araddr_o    (mem_araddr),
    .mem_arvalid_o   (mem_arvalid),
    .mem_rdata_i     (mem_rdata),
    .mem_rvalid_i    (mem_rvalid),
    .inst_o          (inst),
    .pc_o            (pc),
    .valid_o         (valid),
    .ready_i         (ready),
    .resolve_valid_i (resolve_valid),
    .resolve_pc_i    (resolve_pc),
    .spec_o          (spec),
    .good_spec_o     (good_spec),
    .bad_spec_o      (bad_spec)
  );

  bind ifu_top ifu_assertions ifu_assertions_inst (
    .clk           (clk),
    .rst           (rst),
    .mem_araddr_i  (mem_araddr_o),
    .mem_arvalid_i (mem_arvalid_o),
    .mem_rvalid_i  (mem_rvalid_i),
    .valid_i       (valid_o),
    .good_spec_i   (good_spec_o),
    .bad_spec_i    (bad_spec_o),
    .fill_state_i  (ifu_icache_inst.state_q)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string what, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
    assert (act === exp) else
      stop_run($sformatf("error: %s %s: expected %h, actual %h", test_name, what, exp, act));
  endtask

  function automatic logic [XLEN-1:0] pc_of(input int n);
    return PC_INIT + 32'(4 * n);
  endfunction

  // every word an ordinary instruction tagged with its own index
  task automatic fill_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {17'h0, i[7:0], OP_OTHER};
    end
  endtask

  task automatic reset_dut();
    @(posedge clk);
    #1;
    rst           = 1'b1;
    bp_en         = 1'b0;
    resolve_valid = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    got_pc.delete();
    got_inst.delete();
    got_spec.delete();
    exp_pc.delete();
    exp_inst.delete();
    exp_spec.delete();
    mem_reqs = 0;
    good_cnt = 0;
    bad_cnt  = 0;
  endtask

  task automatic expect_word(input int n, input logic spec_flag);
    exp_pc.push_back(pc_of(n));
    exp_inst.push_back(mem[n]);
    exp_spec.push_back(spec_flag);
  endtask

  task automatic wait_transfers(input int n);
    while (got_pc.size() < n) begin
      @(posedge clk);
    end
  endtask

  task automatic send_resolve(input logic [XLEN-1:0] next_pc);
    @(posedge clk);
    #1;
    resolve_valid = 1'b1;
    resolve_pc    = next_pc;
    @(posedge clk);
    #1;
    resolve_valid = 1'b0;
  endtask

  task automatic compare_transfers();
    wait_transfers(exp_pc.size());
    for (int i = 0; i < exp_pc.size(); i++) begin
      check_value($sformatf("pc #%0d", i), exp_pc[i], got_pc[i]);
      check_value($sformatf("inst #%0d", i), exp_inst[i], got_inst[i]);
      check_value($sformatf("spec #%0d", i), 32'(exp_spec[i]), 32'(got_spec[i]));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory, backend and monitor
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    logic [31:0]     r;
    logic [XLEN-1:0] addr;
    forever begin
      @(negedge clk);
      if (!rst && mem_arvalid) begin
        addr     = mem_araddr;
        mem_reqs = mem_reqs + 1;
        r        = $random(seed);
        // answer 1 to 4 cycles later
        repeat (r[1:0] + 1) @(posedge clk);
        #1;
        mem_rdata  = mem[addr[9:2]];
        mem_rvalid = 1'b1;
        @(posedge clk);
        #1;
        mem_rvalid = 1'b0;
      end
    end
  end

  initial begin
    logic [31:0] r;
    forever begin
      @(posedge clk);
      #1;
      r     = $random(seed);
      ready = bp_en ? (r[1:0] != 2'b00) : 1'b1;
    end
  end

  always @(negedge clk) begin
    if (!rst) begin
      if (bp_en && held) begin
        assert (valid && pc == held_pc && inst == held_inst) else
          stop_run($sformatf("error: %s: instruction changed while waiting for ready",
                             test_name));
      end
      held      = valid && !ready;
      held_pc   = pc;
      held_inst = inst;
      if (valid && ready) begin
        got_pc.push_back(pc);
        got_inst.push_back(inst);
        got_spec.push_back(spec);
      end
      good_cnt = good_cnt + good_spec;
      bad_cnt  = bad_cnt + bad_spec;
    end else begin
      held = 1'b0;
    end
  end

  always @(negedge clk) begin
    assert (ifu_top_inst.ifu_assertions_inst.fail_cnt == 0) else
      stop_run($sformatf("error: %s: protocol assertion failed", test_name));
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // eight words fill the whole cache so the second pass needs no memory
  task automatic straight_line_fetch();
    test_name = "straight_line";
    fill_memory();
    mem[7] = {25'h0, OP_BRANCH};
    reset_dut();
    for (int i = 0; i < 16; i++) begin
      expect_word(i % 8, 1'b0);
    end
    wait_transfers(8);
    send_resolve(PC_INIT);
    compare_transfers();
    check_value("memory requests", 32'd8, mem_reqs);
  endtask

  task automatic back_pressure_hold();
    test_name = "back_pressure";
    fill_memory();
    reset_dut();
    bp_en = 1'b1;
    for (int i = 0; i < 20; i++) begin
      expect_word(i, 1'b0);
    end
    compare_transfers();
    bp_en = 1'b0;
  endtask

  task automatic load_branch_stall();
    test_name = "stall";
    fill_memory();
    mem[1] = {25'h0, OP_LOAD};
    mem[3] = {25'h0, OP_BRANCH};
    reset_dut();
    wait_transfers(2);
    repeat (20) @(posedge clk);
    check_value("transfers during load stall", 32'd2, got_pc.size());
    send_resolve(pc_of(2));
    wait_transfers(4);
    repeat (20) @(posedge clk);
    check_value("transfers during branch stall", 32'd4, got_pc.size());
    send_resolve(pc_of(5));
    expect_word(0, 1'b0);
    expect_word(1, 1'b0);
    expect_word(2, 1'b0);
    expect_word(3, 1'b0);
    expect_word(5, 1'b0);
    expect_word(6, 1'b0);
    compare_transfers();
  endtask

  // branch at word 0 trains the target buffer and word 10 then predicts word 8
  task automatic run_prediction(input logic [XLEN-1:0] verdict_pc);
    fill_memory();
    mem[0]  = {25'h0, OP_BRANCH};
    mem[10] = {25'h0, OP_BRANCH};
    reset_dut();
    expect_word(0, 1'b0);
    for (int i = 0; i < 6; i++) begin
      expect_word(8 + i % 3, i >= 3);
    end
    wait_transfers(1);
    send_resolve(pc_of(8));
    wait_transfers(7);
    send_resolve(verdict_pc);
  endtask

  task automatic good_speculation();
    test_name = "good_spec";
    run_prediction(pc_of(8));
    // second copy of the branch is still stalled
    send_resolve(pc_of(11));
    expect_word(11, 1'b0);
    expect_word(12, 1'b0);
    compare_transfers();
    check_value("good pulses", 32'd1, good_cnt);
    check_value("bad pulses", 32'd0, bad_cnt);
  endtask

  task automatic bad_speculation();
    test_name = "bad_spec";
    run_prediction(pc_of(12));
    expect_word(12, 1'b0);
    expect_word(13, 1'b0);
    compare_transfers();
    check_value("good pulses", 32'd0, good_cnt);
    check_value("bad pulses", 32'd1, bad_cnt);
  endtask

  task automatic fence_i_refetch();
    test_name = "fence_i";
    fill_memory();
    mem[1] = {25'h0, OP_LOAD};
    mem[2] = INST_FENCE_I;
    mem[3] = {25'h0, OP_JAL};
    reset_dut();
    for (int i = 0; i < 4; i++) begin
      expect_word(i, 1'b0);
    end
    wait_transfers(2);
    // word 0 is cached with its old value at this point
    mem[0] = {12'h123, 13'h0, OP_OTHER};
    send_resolve(pc_of(2));
    wait_transfers(4);
    send_resolve(PC_INIT);
    expect_word(0, 1'b0);
    expect_word(1, 1'b0);
    compare_transfers();
    check_value("memory requests", 32'd8, mem_reqs);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sequence and watchdog
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD_NS);
    stop_run($sformatf("error: watchdog expired during test %s", test_name));
  end

  initial begin
    rst           = 1'b1;
    ready         = 1'b1;
    resolve_valid = 1'b0;
    resolve_pc    = '0;
    mem_rdata     = '0;
    mem_rvalid    = 1'b0;
    bp_en         = 1'b0;
    held          = 1'b0;
    mem_reqs      = 0;
    good_cnt      = 0;
    bad_cnt       = 0;
    seed          = 32'h5f5da265;
    test_name     = "startup";
    straight_line_fetch();
    back_pressure_hold();
    load_branch_stall();
    good_speculation();
    bad_speculation();
    fence_i_refetch();
    if (ifu_top_inst.ifu_assertions_inst.fail_cnt == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      stop_run("error: protocol assertion failed at the end of the run");
    end
  end

endmodule

// ==== test/ifu_assertions.sv ====
`timescale 1ns/10ps

module ifu_assertions (
  input logic                     clk,
  input logic                     rst,
  input logic [ifu_pkg::XLEN-1:0] mem_araddr_i,
  input logic                     mem_arvalid_i,
  input logic                     mem_rvalid_i,
  input logic                     valid_i,
  input logic                     good_spec_i,
  input logic                     bad_spec_i,
  input ifu_pkg::fill_state_e     fill_state_i
);
  import ifu_pkg::*;

  int fail_cnt = 0;

  // a pending request keeps its address until the word comes back
  addr_held: assert property (@(posedge clk) disable iff (rst)
    mem_arvalid_i && !mem_rvalid_i |=> mem_arvalid_i && $stable(mem_araddr_i))
    else begin
      fail_cnt++;
      $error("memory request dropped or moved before its response");
    end

  // even word of a line goes out first, odd word second
  word_order: assert property (@(posedge clk) disable iff (rst)
    mem_arvalid_i |-> mem_araddr_i[2] == (fill_state_i == FILL_WORD1))
    else begin
      fail_cnt++;
      $error("line fill requested its words out of order");
    end

  no_valid_in_reset: assert property (@(posedge clk)
    rst && $past(rst) |-> !valid_i)
    else begin
      fail_cnt++;
      $error("valid_o high during reset");
    end

  // at most one verdict per resolve
  one_verdict: assert property (@(posedge clk) disable iff (rst)
    !(good_spec_i && bad_spec_i))
    else begin
      fail_cnt++;
      $error("good and bad speculation reported together");
    end

endmodule

// ==== test/tb_clkgen.sv ====
`timescale 1ns/10ps

module tb_clkgen (
  output logic clk_o
);

  // 8 ns period
  initial begin
    clk_o = 1'b0;
    forever begin
      #4 clk_o = ~clk_o;
    end
  end

endmodule

// ==== rtl/ifu_top.sv ====
`timescale 1ns/10ps

module ifu_top (
  input  logic                     clk,
  input  logic                     rst,
  // memory read port
  output logic [ifu_pkg::XLEN-1:0] mem_araddr_o,
  output logic                     mem_arvalid_o,
  input  logic [ifu_pkg::XLEN-1:0] mem_rdata_i,
  input  logic                     mem_rvalid_i,
  // backend
  output logic [ifu_pkg::XLEN-1:0] inst_o,
  output logic [ifu_pkg::XLEN-1:0] pc_o,
  output logic                     valid_o,
  input  logic                     ready_i,
  // resolution
  input  logic                     resolve_valid_i,
  input  logic [ifu_pkg::XLEN-1:0] resolve_pc_i,
  output logic                     spec_o,
  output logic                     good_spec_o,
  output logic                     bad_spec_o
);
  import ifu_pkg::*;

  logic [XLEN-1:0] lookup_pc;
  logic            invalidate;
  logic            hit;
  logic [XLEN-1:0] hit_inst;

  ifu_icache ifu_icache_inst (
    .clk           (clk),
    .rst           (rst),
    .lookup_pc_i   (lookup_pc),
    .invalidate_i  (invalidate),
    .hit_o         (hit),
    .hit_inst_o    (hit_inst),
    .mem_araddr_o  (mem_araddr_o),
    .mem_arvalid_o (mem_arvalid_o),
    .mem_rdata_i   (mem_rdata_i),
    .mem_rvalid_i  (mem_rvalid_i)
  );

  ifu_fetch_ctrl ifu_fetch_ctrl_inst (
    .clk             (clk),
    .rst             (rst),
    .hit_i           (hit),
    .hit_inst_i      (hit_inst),
    .lookup_pc_o     (lookup_pc),
    .invalidate_o    (invalidate),
    .inst_o          (inst_o),
    .pc_o            (pc_o),
    .valid_o         (valid_o),
    .ready_i         (ready_i),
    .resolve_valid_i (resolve_valid_i),
    .resolve_pc_i    (resolve_pc_i),
    .spec_o          (spec_o),
    .good_spec_o     (good_spec_o),
    .bad_spec_o      (bad_spec_o)
  );

endmodule

// ==== rtl/ifu_fetch_ctrl.sv ====
`timescale 1ns/10ps

module ifu_fetch_ctrl (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     hit_i,
  input  logic [ifu_pkg::XLEN-1:0] hit_inst_i,
  output logic [ifu_pkg::XLEN-1:0] lookup_pc_o,
  output logic                     invalidate_o,
  output logic [ifu_pkg::XLEN-1:0] inst_o,
  output logic [ifu_pkg::XLEN-1:0] pc_o,
  output logic                     valid_o,
  input  logic                     ready_i,
  input  logic                     resolve_valid_i,
  input  logic [ifu_pkg::XLEN-1:0] resolve_pc_i,
  output logic                     spec_o,
  output logic                     good_spec_o,
  output logic                     bad_spec_o
);
  import ifu_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic            stall_q;
  logic            stall_ctrl_q;
  logic [XLEN-1:0] btb_q;
  logic            btb_valid_q;
  logic            spec_q;
  logic [XLEN-1:0] pred_q;
  logic            good_q;
  logic            bad_q;

  opcode_e         op;
  logic            is_ctrl;
  logic            is_load;
  logic            is_fence;
  logic            fire;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // predecode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    case (hit_inst_i[6:0])
      OP_JAL, OP_JALR, OP_BRANCH, OP_SYSTEM, OP_LOAD, OP_MISC_MEM: begin
        op = opcode_e'(hit_inst_i[6:0]);
      end
      default: begin
        op = OP_OTHER;
      end
    endcase
  end

  always_comb begin
    is_ctrl  = 1'b0;
    is_load  = 1'b0;
    is_fence = 1'b0;
    case (op)
      OP_JAL, OP_JALR, OP_BRANCH, OP_SYSTEM: is_ctrl = 1'b1;
      OP_LOAD: is_load = 1'b1;
      // plain fence is an ordinary instruction here
      OP_MISC_MEM: is_fence = (hit_inst_i == INST_FENCE_I);
      default: ;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // backend handshake
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign valid_o      = hit_i && !stall_q;
  assign fire         = valid_o && ready_i;
  assign inst_o       = hit_inst_i;
  assign pc_o         = pc_q;
  assign lookup_pc_o  = pc_q;
  assign invalidate_o = fire && is_fence;

  assign spec_o      = spec_q;
  assign good_spec_o = good_q;
  assign bad_spec_o  = bad_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // next pc, stall and speculation
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q        <= PC_INIT;
      stall_q     <= 1'b0;
      btb_valid_q <= 1'b0;
      spec_q      <= 1'b0;
      good_q      <= 1'b0;
      bad_q       <= 1'b0;
    end else begin
      good_q <= 1'b0;
      bad_q  <= 1'b0;

      if (fire) begin
        if (is_ctrl) begin
          if (btb_valid_q && !spec_q) begin
            pc_q   <= btb_q;
            pred_q <= btb_q;
            spec_q <= 1'b1;
          end else begin
            stall_q      <= 1'b1;
            stall_ctrl_q <= 1'b1;
          end
        end else if (is_load) begin
          stall_q      <= 1'b1;
          stall_ctrl_q <= 1'b0;
        end else begin
          pc_q <= pc_q + 32'd4;
        end
      end

      // resolves arrive in order, so with a prediction outstanding
      // the next one always belongs to the predicted instruction
      if (resolve_valid_i) begin
        if (spec_q) begin
          spec_q      <= 1'b0;
          btb_q       <= resolve_pc_i;
          btb_valid_q <= 1'b1;
          if (resolve_pc_i == pred_q) begin
            good_q <= 1'b1;
          end else begin
            // wrong path is dropped, including any stall it raised
            bad_q   <= 1'b1;
            pc_q    <= resolve_pc_i;
            stall_q <= 1'b0;
          end
        end else if (stall_q) begin
          stall_q <= 1'b0;
          pc_q    <= resolve_pc_i;
          if (stall_ctrl_q) begin
            btb_q       <= resolve_pc_i;
            btb_valid_q <= 1'b1;
          end
        end
      end
    end
  end

endmodule

// ==== rtl/ifu_icache.sv ====
`timescale 1ns/10ps

module ifu_icache (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [ifu_pkg::XLEN-1:0] lookup_pc_i,
  input  logic                     invalidate_i,
  output logic                     hit_o,
  output logic [ifu_pkg::XLEN-1:0] hit_inst_o,
  output logic [ifu_pkg::XLEN-1:0] mem_araddr_o,
  output logic                     mem_arvalid_o,
  input  logic [ifu_pkg::XLEN-1:0] mem_rdata_i,
  input  logic                     mem_rvalid_i
);
  import ifu_pkg::*;

  logic [TAG_W-1:0] lookup_tag;
  logic [IDX_W-1:0] lookup_idx;
  logic [OFF_W-1:0] lookup_off;

  logic [XLEN-1:0]  data_q [LINES][WORDS];
  logic [TAG_W-1:0] tag_q [LINES];
  logic [LINES-1:0] valid_q;

  fill_state_e      state_q;
  logic             req_q;
  logic [XLEN-1:0]  addr_q;
  logic [IDX_W-1:0] fill_idx_q;
  logic [TAG_W-1:0] fill_tag_q;

  logic             lookup_ok;
  logic             miss;
  logic             word_in;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // lookup
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign lookup_tag = lookup_pc_i[XLEN-1 -: TAG_W];
  assign lookup_idx = lookup_pc_i[OFF_W+2 +: IDX_W];
  assign lookup_off = lookup_pc_i[2 +: OFF_W];

  // a line being refilled must not be seen half written
  assign lookup_ok  = (state_q == FILL_IDLE) || (state_q == FILL_DONE);
  assign hit_o      = lookup_ok && valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
  assign hit_inst_o = data_q[lookup_idx][lookup_off];

  assign miss    = (state_q == FILL_IDLE) && !hit_o;
  assign word_in = req_q && mem_rvalid_i;

  assign mem_araddr_o  = addr_q;
  assign mem_arvalid_o = req_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fill control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= FILL_IDLE;
      req_q   <= 1'b0;
      valid_q <= '0;
    end else begin
      case (state_q)
        FILL_IDLE: begin
          if (miss) begin
            state_q <= FILL_WORD0;
            req_q   <= 1'b1;
          end
        end
        FILL_WORD0: begin
          if (word_in) begin
            state_q <= FILL_WORD1;
            req_q   <= 1'b0;
          end
        end
        FILL_WORD1: begin
          // one idle cycle on the port between the two words
          if (!req_q) begin
            req_q <= 1'b1;
          end else if (mem_rvalid_i) begin
            req_q               <= 1'b0;
            valid_q[fill_idx_q] <= 1'b1;
            state_q             <= FILL_DONE;
          end
        end
        FILL_DONE: begin
          state_q <= FILL_IDLE;
        end
        default: begin
          state_q <= FILL_IDLE;
        end
      endcase
      // fence.i drops every line
      if (invalidate_i) begin
        valid_q <= '0;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fill address and line storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (miss) begin
      // even word of the line goes out first
      addr_q     <= {lookup_tag, lookup_idx, {OFF_W{1'b0}}, 2'b00};
      fill_idx_q <= lookup_idx;
      fill_tag_q <= lookup_tag;
    end else if ((state_q == FILL_WORD1) && !req_q) begin
      addr_q <= {fill_tag_q, fill_idx_q, {OFF_W{1'b1}}, 2'b00};
    end
    if (word_in) begin
      if (state_q == FILL_WORD0) begin
        data_q[fill_idx_q][0] <= mem_rdata_i;
      end else begin
        data_q[fill_idx_q][WORDS-1] <= mem_rdata_i;
      end
      tag_q[fill_idx_q] <= fill_tag_q;
    end
  end

endmodule

// ==== rtl/ifu_pkg.sv ====
package ifu_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // datapath and cache geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int XLEN  = 32;
  localparam int IDX_W = 2;
  localparam int OFF_W = 1;
  // 2 byte-offset bits below the word offset
  localparam int TAG_W = XLEN - IDX_W - OFF_W - 2;

  localparam int LINES = 1 << IDX_W;
  localparam int WORDS = 1 << OFF_W;

  localparam logic [XLEN-1:0] PC_INIT      = 32'h8000_0000;
  localparam logic [XLEN-1:0] INST_FENCE_I = 32'h0000_100f;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // major opcodes seen by the predecoder, anything else is OP_OTHER
  typedef enum logic [6:0] {
    OP_JAL      = 7'b1101111,
    OP_JALR     = 7'b1100111,
    OP_BRANCH   = 7'b1100011,
    OP_SYSTEM   = 7'b1110011,
    OP_LOAD     = 7'b0000011,
    OP_MISC_MEM = 7'b0001111,
    OP_OTHER    = 7'b0010011
  } opcode_e;

  // line fill walk of the instruction cache
  typedef enum logic [1:0] {
    FILL_IDLE  = 2'd0,
    FILL_WORD0 = 2'd1,
    FILL_WORD1 = 2'd2,
    FILL_DONE  = 2'd3
  } fill_state_e;

endpackage
